// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // Bus widths
    localparam int byte_w = 8;
    localparam int addr_w = 16;

    localparam logic [byte_w-1:0] opc_nop   = 8'hea;  // Held in the IR after reset
    localparam logic [byte_w-1:0] zero_page = 8'h00;  // High address byte for $00 operands

    // Bit positions in the status word
    localparam int stat_n = 7;
    localparam int stat_v = 6;
    localparam int stat_u = 5;    // Always reads 1
    localparam int stat_b = 4;    // Always reads 1
    localparam int stat_d = 3;
    localparam int stat_i = 2;
    localparam int stat_z = 1;
    localparam int stat_c = 0;

    // Internal data bus sources, one-hot
    localparam int db_w     = 5;
    localparam int db_din   = 0;  // Registered bus input
    localparam int db_alu   = 1;
    localparam int db_shift = 2;  // Accumulator shifter
    localparam int db_a     = 3;
    localparam int db_count = 4;  // Increment or decrement unit

    // Bus address sources, one-hot
    localparam int addr_pc = 0;
    localparam int addr_zp = 1;

    // Store data sources, one-hot
    localparam int sto_a = 0;
    localparam int sto_x = 1;
    localparam int sto_y = 2;

    // Opcode byte, matched whole or split aaa_bbb_cc
    typedef union packed {
        logic [byte_w-1:0] raw;
        struct packed {
            logic [2:0] aaa;      // Operation group
            logic [2:0] bbb;      // Addressing mode
            logic [1:0] cc;       // Class
        } fields;
    } opcode_t;

endpackage

// ==== hdl/cpu_ctrl_if.sv ====
`timescale 1ns/1ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    opcode_t           op;          // Current instruction
    logic [db_w-1:0]   db_sel;      // Data bus source, one-hot
    logic              count_sel;   // Counter input, 0 = X, 1 = Y
    logic              count_inc;
    logic              count_dec;
    logic              load_a;
    logic              load_x;
    logic              load_y;
    logic              n_db7;       // N from bit 7 of the data bus
    logic              v_alu;
    logic              v_ir5;       // V from opcode bit 5
    logic              d_ir5;
    logic              i_ir5;
    logic              c_ir5;
    logic              c_alu;
    logic              c_shift;
    logic              z_dbz;       // Z from data bus equal to zero
    logic              pc_inc;
    logic [1:0]        addr_sel;    // PC or zero page, one-hot
    logic              write_en;
    logic [2:0]        store_sel;   // A, X or Y, one-hot
    logic              sync;        // First cycle of an instruction

    modport control (output op, db_sel, count_sel, count_inc, count_dec, load_a, load_x,
                     load_y, n_db7, v_alu, v_ir5, d_ir5, i_ir5, c_ir5, c_alu, c_shift,
                     z_dbz, pc_inc, addr_sel, write_en, store_sel, sync);

    modport datapath (input op, db_sel, count_sel, count_inc, count_dec, load_a, load_x,
                      load_y, n_db7, v_alu, v_ir5, d_ir5, i_ir5, c_ir5, c_alu, c_shift,
                      z_dbz, pc_inc, addr_sel, write_en, store_sel, sync);

    modport alu (input op);

endinterface

// ==== hdl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] data_in,        // Opcode byte straight off the bus
    output logic [byte_w-1:0] debug_opcode,
    cpu_ctrl_if.control       ctrl
);

    localparam int s_byte1 = 0;   // Opcode fetch, previous result written back
    localparam int s_byte2 = 1;   // Operand or dummy fetch
    localparam int s_zp    = 2;   // Zero-page read or write

    logic [2:0] state;            // One-hot
    logic [2:0] next_state;
    opcode_t    opcode;           // Instruction register

    // Length and addressing
    wire logic one_byte = opcode.raw ==? 8'b???_?10_?0;
    wire logic zp_mode  = opcode.fields.bbb == 3'b001;

    // ORA..SBC group, immediate and $00 only
    wire logic alu_mode = (opcode.fields.cc == 2'b01) &&
                          (opcode.fields.bbb == 3'b001 || opcode.fields.bbb == 3'b010);
    wire logic op_arith   = alu_mode && (opcode.fields.aaa[2:1] != 2'b10);
    wire logic op_cmp     = alu_mode && (opcode.fields.aaa == 3'b110);
    wire logic op_adc_sbc = alu_mode && (opcode.fields.aaa[1:0] == 2'b11);
    wire logic op_lda     = alu_mode && (opcode.fields.aaa == 3'b101);
    wire logic op_ldx     = opcode.raw ==? 8'b101_00?_10;      // LDX # and $00
    wire logic op_ldy     = opcode.raw ==? 8'b101_00?_00;      // LDY # and $00
    wire logic op_store   = (opcode.raw ==? 8'b100_001_??) && (opcode.fields.cc != 2'b11);
    wire logic op_acc     = opcode.raw ==? 8'b0??_010_10;      // ASL/ROL/LSR/ROR A

    // Implied one-byte instructions
    wire logic op_tax = opcode.raw == 8'haa;
    wire logic op_tay = opcode.raw == 8'ha8;
    wire logic op_txa = opcode.raw == 8'h8a;
    wire logic op_tya = opcode.raw == 8'h98;
    wire logic op_inx = opcode.raw == 8'he8;
    wire logic op_iny = opcode.raw == 8'hc8;
    wire logic op_dex = opcode.raw == 8'hca;
    wire logic op_dey = opcode.raw == 8'h88;
    wire logic op_clv = opcode.raw == 8'hb8;
    wire logic op_clc_sec = opcode.raw ==? 8'b00?_110_00;
    wire logic op_cli_sei = opcode.raw ==? 8'b01?_110_00;
    wire logic op_cld_sed = opcode.raw ==? 8'b11?_110_00;

    wire logic op_count = op_txa | op_tya | op_inx | op_iny | op_dex | op_dey;
    wire logic upd_a = op_lda | (op_arith & ~op_cmp) | op_acc | op_txa | op_tya;
    wire logic upd_x = op_ldx | op_tax | op_inx | op_dex;
    wire logic upd_y = op_ldy | op_tay | op_iny | op_dey;

    always_comb
    begin
        next_state     = '0;
        ctrl.db_sel    = '0;
        ctrl.count_sel = 1'b0;
        ctrl.count_inc = 1'b0;
        ctrl.count_dec = 1'b0;
        ctrl.load_a    = 1'b0;
        ctrl.load_x    = 1'b0;
        ctrl.load_y    = 1'b0;
        ctrl.n_db7     = 1'b0;
        ctrl.v_alu     = 1'b0;
        ctrl.v_ir5     = 1'b0;
        ctrl.d_ir5     = 1'b0;
        ctrl.i_ir5     = 1'b0;
        ctrl.c_ir5     = 1'b0;
        ctrl.c_alu     = 1'b0;
        ctrl.c_shift   = 1'b0;
        ctrl.z_dbz     = 1'b0;
        ctrl.pc_inc    = 1'b0;
        ctrl.addr_sel  = '0;
        ctrl.write_en  = 1'b0;
        ctrl.store_sel = '0;

        if (state[s_byte1])
        begin
            next_state[s_byte2]    = 1'b1;
            ctrl.addr_sel[addr_pc] = 1'b1;
            ctrl.pc_inc            = 1'b1;

            // IR still holds the previous instruction here
            ctrl.db_sel[db_din]   = op_lda | op_ldx | op_ldy;
            ctrl.db_sel[db_alu]   = op_arith;
            ctrl.db_sel[db_shift] = op_acc;
            ctrl.db_sel[db_a]     = op_tax | op_tay;
            ctrl.db_sel[db_count] = op_count;
            ctrl.count_sel = op_tya | op_iny | op_dey;   // Y side of the counter
            ctrl.count_inc = op_inx | op_iny;
            ctrl.count_dec = op_dex | op_dey;
            ctrl.load_a    = upd_a;
            ctrl.load_x    = upd_x;
            ctrl.load_y    = upd_y;
            ctrl.n_db7     = upd_a | upd_x | upd_y | op_cmp;
            ctrl.z_dbz     = upd_a | upd_x | upd_y | op_cmp;
            ctrl.v_alu     = op_adc_sbc;
            ctrl.v_ir5     = op_clv;
            ctrl.d_ir5     = op_cld_sed;
            ctrl.i_ir5     = op_cli_sei;
            ctrl.c_ir5     = op_clc_sec;
            ctrl.c_alu     = op_adc_sbc | op_cmp;
            ctrl.c_shift   = op_acc;
        end

        if (state[s_byte2])
        begin
            ctrl.addr_sel[addr_pc] = 1'b1;
            ctrl.pc_inc            = ~one_byte;    // Implied ops reread the next opcode
            next_state[s_zp]       = zp_mode;
            next_state[s_byte1]    = ~zp_mode;
        end

        if (state[s_zp])
        begin
            ctrl.addr_sel[addr_zp] = 1'b1;          // Operand byte is the address low
            ctrl.write_en          = op_store;
            ctrl.store_sel[sto_y]  = opcode.fields.cc == 2'b00;
            ctrl.store_sel[sto_a]  = opcode.fields.cc == 2'b01;
            ctrl.store_sel[sto_x]  = opcode.fields.cc == 2'b10;
            next_state[s_byte1]    = 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= 3'b001;                  // Start in byte1
            opcode.raw <= opc_nop;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state[s_byte1])
                opcode.raw <= data_in;             // Latch the fetched opcode
        end
    end

    assign ctrl.op      = opcode;
    assign ctrl.sync    = state[s_byte1];
    assign debug_opcode = opcode.raw;

endmodule

// ==== hdl/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*;
(
    input  logic [byte_w-1:0] a,             // Accumulator
    input  logic [byte_w-1:0] b,             // Operand from the bus
    input  logic              carry_in,
    output logic [byte_w-1:0] result,
    output logic              carry_out,
    output logic              overflow,
    output logic [byte_w-1:0] shift_result,
    output logic              shift_carry,
    cpu_ctrl_if.alu           ctrl
);

    wire logic [2:0] aaa = ctrl.op.fields.aaa;  // ORA,AND,EOR,ADC,STA,LDA,CMP,SBC

    // CMP and SBC add the complement, CMP ignores C
    wire logic              sub    = aaa[2];
    wire logic              cin    = carry_in | ~aaa[0];
    wire logic [byte_w-1:0] addend = sub ? ~b : b;
    wire logic [byte_w:0]   sum    = a + addend + byte_w'(cin);  // Binary only

    always_comb
    begin
        case (aaa)
            3'd0: result = a | b;
            3'd1: result = a & b;
            3'd2: result = a ^ b;
            3'd3, 3'd6, 3'd7: result = sum[byte_w-1:0];
            default: result = '0;              // STA and LDA take no ALU result
        endcase
    end

    // Signed overflow when both inputs disagree with the sum sign
    assign overflow  = (a[byte_w-1] ^ sum[byte_w-1]) & (addend[byte_w-1] ^ sum[byte_w-1]);
    assign carry_out = sum[byte_w];

    // Accumulator shifter, aaa 0..3 = ASL, ROL, LSR, ROR
    wire logic rotate = aaa[0];
    wire logic right  = aaa[1];
    wire logic fill   = carry_in & rotate;   // Bit shifted in

    always_comb
    begin
        if (right)
            {shift_result, shift_carry} = {fill, a};
        else
            {shift_carry, shift_result} = {a, fill};
    end

endmodule

// ==== hdl/cpu_registers.sv ====
`timescale 1ns/1ps

module cpu_registers import cpu_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] data_in,
    input  logic [byte_w-1:0] alu_result,
    input  logic              alu_carry,
    input  logic              alu_overflow,
    input  logic [byte_w-1:0] shift_result,
    input  logic              shift_carry,
    output logic [byte_w-1:0] a,
    output logic [byte_w-1:0] x,
    output logic [byte_w-1:0] y,
    output logic              carry,          // C flag into the ALU
    output logic [byte_w-1:0] status,
    cpu_ctrl_if.datapath      ctrl
);

    logic flag_n, flag_v, flag_d, flag_i, flag_z, flag_c;

    // Counter unit for INX/INY/DEX/DEY and the X/Y to A transfers
    wire logic [byte_w-1:0] count_in  = ctrl.count_sel ? y : x;
    wire logic [byte_w-1:0] count_out =
        count_in + {byte_w{ctrl.count_dec}} + byte_w'(ctrl.count_inc);

    // Internal data bus, sources are one-hot
    wire logic [byte_w-1:0] db =
        ({byte_w{ctrl.db_sel[db_din]}}   & data_in)      |
        ({byte_w{ctrl.db_sel[db_alu]}}   & alu_result)   |
        ({byte_w{ctrl.db_sel[db_shift]}} & shift_result) |
        ({byte_w{ctrl.db_sel[db_a]}}     & a)            |
        ({byte_w{ctrl.db_sel[db_count]}} & count_out);

    wire logic ir5 = ctrl.op.raw[5];    // Set or clear for flag instructions

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            a      <= '0;
            x      <= '0;
            y      <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_d <= 1'b0;
            flag_i <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (enable)
        begin
            if (ctrl.load_a) a <= db;
            if (ctrl.load_x) x <= db;
            if (ctrl.load_y) y <= db;
            if (ctrl.n_db7) flag_n <= db[byte_w-1];
            if (ctrl.z_dbz) flag_z <= (db == '0);
            if (ctrl.v_alu)
                flag_v <= alu_overflow;
            else if (ctrl.v_ir5)
                flag_v <= 1'b0;         // CLV clears V whatever bit 5 holds
            if (ctrl.d_ir5) flag_d <= ir5;
            if (ctrl.i_ir5) flag_i <= ir5;
            if (ctrl.c_alu)
                flag_c <= alu_carry;
            else if (ctrl.c_shift)
                flag_c <= shift_carry;
            else if (ctrl.c_ir5)
                flag_c <= ir5;
        end
    end

    always_comb
    begin
        status         = '0;
        status[stat_n] = flag_n;
        status[stat_v] = flag_v;
        status[stat_u] = 1'b1;        // Fixed bits
        status[stat_b] = 1'b1;
        status[stat_d] = flag_d;      // Stored only, adder stays binary
        status[stat_i] = flag_i;
        status[stat_z] = flag_z;
        status[stat_c] = flag_c;
    end

    assign carry = flag_c;

endmodule

// ==== hdl/cpu_address.sv ====
`timescale 1ns/1ps

module cpu_address import cpu_pkg::*;
#(
    parameter logic [addr_w-1:0] reset_pc = 16'h0200
)
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] io_data_in,     // Combinational memory read
    input  logic [byte_w-1:0] a,
    input  logic [byte_w-1:0] x,
    input  logic [byte_w-1:0] y,
    output logic [addr_w-1:0] address,
    output logic [byte_w-1:0] data_out,
    output logic [byte_w-1:0] data_in,        // Bus byte from the last cycle
    output logic [addr_w-1:0] pc,
    cpu_ctrl_if.datapath      ctrl
);

    // Bus address, PC or zero page indexed by the operand byte
    assign address = ({addr_w{ctrl.addr_sel[addr_pc]}} & pc) |
                     ({addr_w{ctrl.addr_sel[addr_zp]}} & {zero_page, data_in});

    // Store data for STA/STX/STY
    assign data_out = ({byte_w{ctrl.store_sel[sto_a]}} & a) |
                      ({byte_w{ctrl.store_sel[sto_x]}} & x) |
                      ({byte_w{ctrl.store_sel[sto_y]}} & y);

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= reset_pc;                   // No vector fetch
        else if (enable)
            pc <= pc + addr_w'(ctrl.pc_inc);
    end

    // Written byte is seen as read data after a store
    always_ff @(posedge clock)
    begin
        if (enable)
            data_in <= ctrl.write_en ? data_out : io_data_in;
    end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*;
#(
    parameter logic [addr_w-1:0] reset_pc = 16'h0200
)
(
    input  logic              clock,
    input  logic              reset,
    input  logic              io_enable,        // Stall when low
    input  logic [byte_w-1:0] io_data_in,
    output logic [addr_w-1:0] io_address,
    output logic [byte_w-1:0] io_data_out,
    output logic              io_write_enable,
    output logic              io_sync,
    output logic [byte_w-1:0] io_debug_opcode,
    output logic [addr_w-1:0] io_debug_pc,
    output logic [byte_w-1:0] io_debug_a,
    output logic [byte_w-1:0] io_debug_x,
    output logic [byte_w-1:0] io_debug_y,
    output logic [byte_w-1:0] io_debug_p
);

    cpu_ctrl_if ctrl ();

    logic [byte_w-1:0] data_in;               // Registered bus byte
    logic [byte_w-1:0] alu_result, shift_result;
    logic              carry, alu_carry, alu_overflow, shift_carry;

    cpu_control u_control (.clock(clock), .reset(reset), .enable(io_enable),
        .data_in(io_data_in), .debug_opcode(io_debug_opcode), .ctrl(ctrl));

    cpu_alu u_alu (.a(io_debug_a), .b(data_in), .carry_in(carry), .result(alu_result),
        .carry_out(alu_carry), .overflow(alu_overflow), .shift_result(shift_result),
        .shift_carry(shift_carry), .ctrl(ctrl));

    cpu_registers u_registers (.clock(clock), .reset(reset), .enable(io_enable),
        .data_in(data_in), .alu_result(alu_result), .alu_carry(alu_carry),
        .alu_overflow(alu_overflow), .shift_result(shift_result), .shift_carry(shift_carry),
        .a(io_debug_a), .x(io_debug_x), .y(io_debug_y), .carry(carry),
        .status(io_debug_p), .ctrl(ctrl));

    cpu_address #(.reset_pc(reset_pc)) u_address (.clock(clock), .reset(reset),
        .enable(io_enable), .io_data_in(io_data_in), .a(io_debug_a), .x(io_debug_x),
        .y(io_debug_y), .address(io_address), .data_out(io_data_out), .data_in(data_in),
        .pc(io_debug_pc), .ctrl(ctrl));

    assign io_sync         = ctrl.sync;
    assign io_write_enable = ctrl.write_en;

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [15:0] reset_pc = 16'h0200;
    localparam int reset_cycles = 16;
    localparam int n_fetch = 100;                  // Mixed program for the fetch checks
    localparam int n_load  = 300;
    localparam int n_alu   = 300;                  // Also replayed with stalls
    localparam int n_store = 150;

    // Three cycles per instruction at most, plus reset and NOP tail per test
    localparam int total_instr  = n_fetch + n_load + 2 * n_alu + n_store;
    localparam int test_cycles  = 3 * total_instr + 6 * (reset_cycles + 12);
    localparam int stall_cycles = 3 * 3 * n_alu;   // Allowance for the stalled replay
    localparam int max_cycles   = 3 * test_cycles + stall_cycles;

    // Opcode pools of 20 entries, entry 0 in the low byte
    localparam logic [159:0] load_ops = {8'ha9, 8'ha5, 8'ha2, 8'ha6, 8'ha0, 8'ha4, 8'haa,
        8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88, 8'h0a, 8'h2a, 8'h4a, 8'h6a,
        8'h18, 8'h38};
    localparam logic [159:0] alu_ops = {8'h09, 8'h05, 8'h29, 8'h25, 8'h49, 8'h45, 8'h69,
        8'h65, 8'hc9, 8'hc5, 8'he9, 8'he5, 8'ha9, 8'hb8, 8'h18, 8'h38, 8'hf8, 8'hd8,
        8'h78, 8'h58};
    localparam logic [159:0] store_ops = {8'h85, 8'h86, 8'h84, 8'h85, 8'h86, 8'h84, 8'h85,
        8'h86, 8'h84, 8'ha9, 8'ha5, 8'ha2, 8'ha6, 8'ha0, 8'ha4, 8'he8, 8'hc8, 8'hca,
        8'h88, 8'haa};

    logic        clock;
    logic        reset;
    logic        io_enable;
    logic [7:0]  io_data_in;
    logic [15:0] io_address;
    logic [7:0]  io_data_out;
    logic        io_write_enable;
    logic        io_sync;
    logic [7:0]  io_debug_opcode;
    logic [15:0] io_debug_pc;
    logic [7:0]  io_debug_a;
    logic [7:0]  io_debug_x;
    logic [7:0]  io_debug_y;
    logic [7:0]  io_debug_p;

    logic [7:0]  mem [0:65535];      // Flat 64 KiB memory
    logic [7:0]  model_zp [0:127];   // Model view of the zero page in use
    logic [23:0] exp_writes [$];     // Pending stores, {address, data}
    logic [7:0]  m_a, m_x, m_y;      // Model registers
    logic [15:0] m_pc;
    logic        m_n, m_v, m_d, m_i, m_z, m_c;
    logic [31:0] rng;
    logic [31:0] saved_rng;          // Replays the ALU program
    int          stores_expected;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          errs_at_start;
    int          i;

    cpu_top #(.reset_pc(reset_pc)) dut (.clock(clock), .reset(reset), .io_enable(io_enable),
        .io_data_in(io_data_in), .io_address(io_address), .io_data_out(io_data_out),
        .io_write_enable(io_write_enable), .io_sync(io_sync),
        .io_debug_opcode(io_debug_opcode), .io_debug_pc(io_debug_pc), .io_debug_a(io_debug_a),
        .io_debug_x(io_debug_x), .io_debug_y(io_debug_y), .io_debug_p(io_debug_p));

    assign io_data_in = mem[io_address];   // Combinational read

    always #20 clock = ~clock;

    // Stores land at the edge, only while the core runs
    always @(posedge clock)
    begin
        if (io_enable && io_write_enable)
            mem[io_address] <= io_data_out;
    end

    // Watchdog
    always @(posedge clock)
    begin
        cycles = cycles + 1;
        if (cycles > max_cycles)
        begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("mismatch %s: got %0h, expected %0h", name, got, expected);
            errors++;
        end
    endtask

    function automatic logic [7:0] pick_opcode(input int pool, input int idx);
        case (pool)
            1: return load_ops[8*idx +: 8];
            2: return alu_ops[8*idx +: 8];
            default: return store_ops[8*idx +: 8];
        endcase
    endfunction

    function automatic bit is_zero_page(input logic [7:0] op);
        case (op)
            8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5, 8'ha5, 8'ha6, 8'ha4,
            8'h85, 8'h86, 8'h84: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Implied ops in these pools all end in 8 or A
    function automatic logic [15:0] instr_length(input logic [7:0] op);
        return (op[3:0] == 4'h8 || op[3:0] == 4'ha) ? 16'd1 : 16'd2;
    endfunction

    function automatic logic [9:0] add_with_carry(input logic [7:0] a, input logic [7:0] b,
                                                  input logic cin);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b} + {8'h00, cin};
        // Overflow when both operands share a sign the sum lacks
        return {sum[8], (a[7] == b[7]) && (sum[7] != a[7]), sum[7:0]};
    endfunction

    function automatic logic [7:0] status_byte();
        return {m_n, m_v, 2'b11, m_d, m_i, m_z, m_c};
    endfunction

    // One instruction of the reference model at m_pc
    task automatic step_model();
        logic [7:0] op;
        logic [7:0] opr;
        logic [7:0] val;
        logic [7:0] res;
        logic [2:0] dest;      // 0 none, 1 A, 2 X, 3 Y, 4 flags only, 5 store
        logic       unused_v;
        op   = mem[m_pc];
        opr  = mem[m_pc + 16'd1];
        val  = is_zero_page(op) ? model_zp[opr[6:0]] : opr;
        dest = 3'd0;
        res  = 8'h00;
        m_pc = m_pc + instr_length(op);
        case (op)
            8'h09, 8'h05: {dest, res} = {3'd1, m_a | val};
            8'h29, 8'h25: {dest, res} = {3'd1, m_a & val};
            8'h49, 8'h45: {dest, res} = {3'd1, m_a ^ val};
            8'h69, 8'h65: {dest, m_c, m_v, res} = {3'd1, add_with_carry(m_a, val, m_c)};
            8'he9, 8'he5: {dest, m_c, m_v, res} = {3'd1, add_with_carry(m_a, ~val, m_c)};
            8'hc9, 8'hc5: {dest, m_c, unused_v, res} = {3'd4, add_with_carry(m_a, ~val, 1'b1)};
            8'ha9, 8'ha5: {dest, res} = {3'd1, val};
            8'ha2, 8'ha6: {dest, res} = {3'd2, val};
            8'ha0, 8'ha4: {dest, res} = {3'd3, val};
            8'h85: {dest, res} = {3'd5, m_a};
            8'h86: {dest, res} = {3'd5, m_x};
            8'h84: {dest, res} = {3'd5, m_y};
            8'haa: {dest, res} = {3'd2, m_a};
            8'ha8: {dest, res} = {3'd3, m_a};
            8'h8a: {dest, res} = {3'd1, m_x};
            8'h98: {dest, res} = {3'd1, m_y};
            8'he8: {dest, res} = {3'd2, m_x + 8'd1};
            8'hc8: {dest, res} = {3'd3, m_y + 8'd1};
            8'hca: {dest, res} = {3'd2, m_x - 8'd1};
            8'h88: {dest, res} = {3'd3, m_y - 8'd1};
            8'h0a: {dest, m_c, res} = {3'd1, m_a, 1'b0};   // ASL
            8'h2a: {dest, m_c, res} = {3'd1, m_a, m_c};    // ROL
            8'h4a: {dest, res, m_c} = {3'd1, 1'b0, m_a};   // LSR
            8'h6a: {dest, res, m_c} = {3'd1, m_c, m_a};    // ROR
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'h58: m_i = 1'b0;
            8'h78: m_i = 1'b1;
            8'hb8: m_v = 1'b0;
            8'hd8: m_d = 1'b0;
            8'hf8: m_d = 1'b1;
            default: ;                                     // NOP
        endcase
        case (dest)
            3'd1: m_a = res;
            3'd2: m_x = res;
            3'd3: m_y = res;
            3'd5:
            begin
                model_zp[opr[6:0]] = res;
                exp_writes.push_back({8'h00, opr, res});   // Zero page is $00xx
                stores_expected++;
            end
            default: ;
        endcase
        if (dest >= 3'd1 && dest <= 3'd4)
        begin
            m_n = res[7];
            m_z = (res == 8'h00);
        end
    endtask

    // Random zero page and program at reset_pc; kind 0 mixes all pools
    task automatic gen_program(input int kind, input int n);
        int          k;
        int          pool;
        logic [15:0] pc;
        logic [31:0] r;
        logic [7:0]  op;
        for (k = 0; k < 128; k++)
        begin
            r = next_rand();
            mem[k]      = r[7:0];
            model_zp[k] = r[7:0];
        end
        pc = reset_pc;
        for (k = 0; k < n; k++)
        begin
            pool    = (kind == 0) ? int'(next_rand() % 3) + 1 : kind;
            op      = pick_opcode(pool, int'(next_rand() % 20));
            r       = next_rand();
            mem[pc] = op;
            if (instr_length(op) == 16'd2)
                mem[pc + 16'd1] = is_zero_page(op) ? {1'b0, r[6:0]} : r[7:0];   // Below $80
            pc = pc + instr_length(op);
        end
        for (k = 0; k < 8; k++)
            mem[pc + 16'(k)] = 8'hea;   // NOP tail
    endtask

    // Called right after a rising edge
    task automatic apply_reset();
        reset     <= 1'b1;
        io_enable <= 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_program(input int n, input bit stall);
        int          checks;
        int          writes;
        int          k;
        bit          pending;
        logic [23:0] w;
        checks  = 0;
        writes  = 0;
        pending = 1'b0;
        exp_writes.delete();
        stores_expected = 0;
        {m_a, m_x, m_y} = '0;
        {m_n, m_v, m_d, m_i, m_z, m_c} = '0;
        m_pc = reset_pc;
        apply_reset();
        while (checks <= n)
        begin
            @(negedge clock);                     // Outputs settled mid-cycle
            if (io_enable)
            begin
                if (pending)
                begin
                    // Results of all instructions before the one just fetched
                    compare("io_debug_a", io_debug_a, m_a);
                    compare("io_debug_x", io_debug_x, m_x);
                    compare("io_debug_y", io_debug_y, m_y);
                    compare("io_debug_p", io_debug_p, status_byte());
                    compare("io_debug_opcode", io_debug_opcode, mem[m_pc]);  // Just latched
                    pending = 1'b0;
                    checks++;
                    if (checks <= n)
                        step_model();
                end
                if (io_sync)
                begin
                    compare("io_address", io_address, m_pc);   // Opcode fetch address
                    compare("io_debug_pc", io_debug_pc, m_pc);
                    pending = 1'b1;
                end
                if (io_write_enable)
                begin
                    writes++;
                    if (exp_writes.size() == 0)
                    begin
                        $display("write to %h with no store instruction pending", io_address);
                        errors++;
                    end
                    else
                    begin
                        w = exp_writes.pop_front();
                        compare("io_address", io_address, w[23:8]);
                        compare("io_data_out", io_data_out, w[7:0]);
                    end
                end
            end
            @(posedge clock);
            io_enable <= stall ? (next_rand() % 3 != 0) : 1'b1;   // About a third low
        end
        compare("write count", writes, stores_expected);
        for (k = 0; k < 128; k++)
            compare($sformatf("mem[%02h]", k), mem[k], model_zp[k]);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial
    begin
        clock        = 1'b0;
        reset        = 1'b1;
        io_enable    = 1'b0;
        rng          = 32'd31893;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        for (i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0];        // Background fill
        @(posedge clock);

        errs_at_start = errors;
        apply_reset();
        @(negedge clock);
        compare("io_sync", io_sync, 1'b1);
        compare("io_write_enable", io_write_enable, 1'b0);
        compare("io_address", io_address, reset_pc);
        compare("io_debug_p", io_debug_p, 8'h30);
        compare("io_debug_opcode", io_debug_opcode, 8'hea);   // NOP in the IR
        @(posedge clock);
        report_test(1, "reset", errs_at_start);

        errs_at_start = errors;
        gen_program(0, n_fetch);
        run_program(n_fetch, 1'b0);
        report_test(2, "fetch sequence", errs_at_start);

        errs_at_start = errors;
        gen_program(1, n_load);
        run_program(n_load, 1'b0);
        report_test(3, "loads, transfers, counters, shifts", errs_at_start);

        saved_rng     = rng;
        errs_at_start = errors;
        gen_program(2, n_alu);
        run_program(n_alu, 1'b0);
        report_test(4, "ALU operations", errs_at_start);

        errs_at_start = errors;
        gen_program(3, n_store);
        run_program(n_store, 1'b0);
        report_test(5, "stores", errs_at_start);

        rng           = saved_rng;          // Same program and zero page as test 4
        errs_at_start = errors;
        gen_program(2, n_alu);
        run_program(n_alu, 1'b1);
        report_test(6, "stall", errs_at_start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/cpu_pkg.sv
hdl/cpu_ctrl_if.sv
hdl/cpu_control.sv
hdl/cpu_alu.sv
hdl/cpu_registers.sv
hdl/cpu_address.sv
hdl/cpu_top.sv
sim/cpu_tb.sv
